// File: verilog/periph_pkg.sv
// shared widths, slot numbers, UART operation codes and reset values; import where needed
`default_nettype none

package periph_pkg;

   // host bus
   localparam int HID_ADDR_W = 18;
   localparam int HID_DATA_W = 64;
   localparam int HID_BE_W   = 8;

   // slot numbers on hid_addr[17:15]
   localparam logic [2:0] SLOT_BOARD = 3'd2;
   localparam logic [2:0] SLOT_UART  = 3'd6;

   localparam int CNT_W  = 12;                    // fifo counter width
   localparam int BAUD_W = 16;

   localparam logic [BAUD_W-1:0] BAUD_RESET = 16'd54;   // clocks per bit

   // board register word indices
   localparam logic [3:0]  LED_INDEX      = 4'd15;
   localparam logic [4:0]  DIP_INDEX      = 5'd31;
   localparam logic [31:0] BOARD_UNMAPPED = 32'hDEADBEEF;

   // write operations, selected by hid_addr[13:12]
   typedef enum logic [1:0] {
      UART_OP_TX   = 2'd0,
      UART_OP_RX   = 2'd1,
      UART_OP_BAUD = 2'd2
   } uart_op_t;

   typedef enum logic [2:0] {
      UTX_IDLE, UTX_EMPTY, UTX_POP, UTX_START, UTX_INUSE
   } utx_state_t;

endpackage

`default_nettype wire

// File: verilog/host_slot_if.sv
// decoded host access for one slot plus its read data; the top drives it, a slot block consumes it
`timescale 1ns/1ps
`default_nettype none

interface host_slot_if
   import periph_pkg::*;
   ();

   logic                  sel;     // slot addressed and hid_en high
   logic                  wr;      // sel with any byte enable
   logic [14:0]           addr;    // offset within the slot
   logic [HID_DATA_W-1:0] wdata;
   logic [HID_DATA_W-1:0] rdata;

   modport host (output sel, wr, addr, wdata, input rdata);
   modport slot (input sel, wr, addr, wdata, output rdata);

endinterface

`default_nettype wire

// File: verilog/sync_fifo.sv
// single-clock FIFO with a registered head output and free-running write/read counters
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
   import periph_pkg::*;
   #(
      parameter int WIDTH      = 9,
      parameter int DEPTH_LOG2 = 4
   )
   (
      input  wire                msoc_clk,
      input  wire                rstn,
      input  wire                wr_en_i,
      input  wire  [WIDTH-1:0]   din_i,
      input  wire                rd_en_i,
      output logic [WIDTH-1:0]   dout_o,
      output logic               full_o,
      output logic               empty_o,
      output logic [CNT_W-1:0]   wrcount_o,
      output logic [CNT_W-1:0]   rdcount_o
   );

   localparam logic [CNT_W-1:0] DEPTH = CNT_W'(2 ** DEPTH_LOG2);

   logic [WIDTH-1:0] mem [2 ** DEPTH_LOG2];
   logic [CNT_W-1:0] level;
   logic [CNT_W-1:0] rd_next;
   logic             wr_ok;
   logic             rd_ok;

   assign level   = wrcount_o - rdcount_o;   // counters double as pointers
   assign full_o  = (level == DEPTH);
   assign empty_o = (level == '0);
   assign wr_ok   = wr_en_i & ~full_o;       // push to full is dropped
   assign rd_ok   = rd_en_i & ~empty_o;
   assign rd_next = rd_ok ? rdcount_o + CNT_W'(1) : rdcount_o;

   always_ff @(posedge msoc_clk)
      if (wr_ok)
         mem[wrcount_o[DEPTH_LOG2-1:0]] <= din_i;

   // dout_o always holds the entry at the head
   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         wrcount_o <= '0;
         rdcount_o <= '0;
         dout_o    <= '0;
      end
      else
      begin
         if (wr_ok)
            wrcount_o <= wrcount_o + CNT_W'(1);
         rdcount_o <= rd_next;
         if (wr_ok && (wrcount_o == rd_next))
            dout_o <= din_i;                            // write lands at the head
         else if (rd_ok && (rd_next != wrcount_o))
            dout_o <= mem[rd_next[DEPTH_LOG2-1:0]];     // next entry moves up
      end

endmodule

`default_nettype wire

// File: verilog/uart_line.sv
// UART serializer and deserializer with a three-sample majority filter on the receive pin
`timescale 1ns/1ps
`default_nettype none

module uart_line
   import periph_pkg::*;
   (
      input  wire                msoc_clk,
      input  wire                rstn,
      input  wire  [BAUD_W-1:0]  baud_i,
      input  wire                tx_start_i,
      input  wire  [7:0]         tx_byte_i,
      output logic               tx_busy_o,
      output logic               uart_tx_o,
      input  wire                uart_rx_i,
      output logic               rx_valid_o,
      output logic [7:0]         rx_byte_o,
      output logic               rx_err_o
   );

   logic [9:0]        tx_shift_q;
   logic [3:0]        tx_bits_q;
   logic [BAUD_W-1:0] tx_cnt_q;
   logic [2:0]        rx_samp_q;
   logic              rx_maj;
   logic              rx_maj_q;
   logic              rx_busy_q;
   logic [3:0]        rx_bits_q;
   logic [BAUD_W-1:0] rx_cnt_q;

   assign uart_tx_o = tx_shift_q[0];   // idles high, ones shift in behind the frame

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         tx_shift_q <= '1;
         tx_bits_q  <= '0;
         tx_cnt_q   <= '0;
         tx_busy_o  <= 1'b0;
      end
      else if (!tx_busy_o)
      begin
         if (tx_start_i)
         begin
            tx_shift_q <= {1'b1, tx_byte_i, 1'b0};   // stop, data lsb first, start
            tx_bits_q  <= '0;
            tx_cnt_q   <= '0;
            tx_busy_o  <= 1'b1;
         end
      end
      else if (tx_cnt_q == baud_i - 1'b1)
      begin
         tx_cnt_q   <= '0;
         tx_shift_q <= {1'b1, tx_shift_q[9:1]};
         tx_bits_q  <= tx_bits_q + 1'b1;
         if (tx_bits_q == 4'd9)
            tx_busy_o <= 1'b0;                     // stop bit done
      end
      else
         tx_cnt_q <= tx_cnt_q + 1'b1;

   assign rx_maj = (rx_samp_q[0] & rx_samp_q[1]) | (rx_samp_q[0] & rx_samp_q[2]) |
                   (rx_samp_q[1] & rx_samp_q[2]);

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         rx_samp_q  <= '1;
         rx_maj_q   <= 1'b1;
         rx_busy_q  <= 1'b0;
         rx_bits_q  <= '0;
         rx_cnt_q   <= '0;
         rx_byte_o  <= '0;
         rx_valid_o <= 1'b0;
         rx_err_o   <= 1'b0;
      end
      else
      begin
         rx_samp_q  <= {rx_samp_q[1:0], uart_rx_i};
         rx_maj_q   <= rx_maj;
         rx_valid_o <= 1'b0;
         if (!rx_busy_q)
         begin
            if (rx_maj_q && !rx_maj)               // start edge
            begin
               rx_busy_q <= 1'b1;
               rx_bits_q <= '0;
               rx_cnt_q  <= baud_i >> 1;           // aim at mid bit
            end
         end
         else if (rx_cnt_q != '0)
            rx_cnt_q <= rx_cnt_q - 1'b1;
         else
         begin
            rx_cnt_q  <= baud_i - 1'b1;
            rx_bits_q <= rx_bits_q + 1'b1;
            if (rx_bits_q == 4'd0)
            begin
               if (rx_maj)
                  rx_busy_q <= 1'b0;               // glitch, not a start bit
            end
            else if (rx_bits_q == 4'd9)
            begin
               rx_busy_q  <= 1'b0;
               rx_valid_o <= 1'b1;
               rx_err_o   <= ~rx_maj;              // stop bit must be high
            end
            else
               rx_byte_o <= {rx_maj, rx_byte_o[7:1]};
         end
      end

endmodule

`default_nettype wire

// File: verilog/uart_regs.sv
// UART slot registers; turns host writes into FIFO push/pop and baud loads, feeds the serializer
`timescale 1ns/1ps
`default_nettype none

module uart_regs
   import periph_pkg::*;
   #(parameter int FIFO_DEPTH_LOG2 = 4)
   (
      input  wire                msoc_clk,
      input  wire                rstn,
      host_slot_if.slot          bus,
      output logic [BAUD_W-1:0]  baud_o,
      output logic               tx_start_o,
      output logic [7:0]         tx_byte_o,
      input  wire                tx_busy_i,
      input  wire                rx_valid_i,
      input  wire  [7:0]         rx_byte_i,
      input  wire                rx_err_i,
      output logic               uart_irq_o
   );

   uart_op_t         op;
   utx_state_t       utx_q;
   utx_state_t       utx_d;
   logic             reg_wr;
   logic             tx_push;
   logic             rx_pop;
   logic             tx_full;
   logic             tx_empty;
   logic             rx_full;
   logic             rx_empty;
   logic [8:0]       tx_dout;
   logic [8:0]       rx_dout;
   logic [CNT_W-1:0] tx_wrcount;
   logic [CNT_W-1:0] tx_rdcount;
   logic [CNT_W-1:0] rx_wrcount;
   logic [CNT_W-1:0] rx_rdcount;

   assign reg_wr     = bus.wr & bus.addr[14];
   assign op         = uart_op_t'(bus.addr[13:12]);
   assign tx_push    = reg_wr & (op == UART_OP_TX);
   assign rx_pop     = reg_wr & (op == UART_OP_RX);
   assign tx_start_o = (utx_q == UTX_START);
   assign uart_irq_o = ~rx_empty;   // pending while anything is received

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         baud_o <= BAUD_RESET;
         utx_q  <= UTX_IDLE;
      end
      else
      begin
         utx_q <= utx_d;
         if (reg_wr && (op == UART_OP_BAUD))
            baud_o <= bus.wdata[BAUD_W-1:0];
      end

   // head leaves the fifo in POP, hold it for START
   always_ff @(posedge msoc_clk)
      if (utx_q == UTX_POP)
         tx_byte_o <= tx_dout[7:0];

   always_comb
   begin
      utx_d = utx_q;
      case (utx_q)
         UTX_IDLE:  utx_d = UTX_EMPTY;
         UTX_EMPTY: if (!tx_empty) utx_d = UTX_POP;
         UTX_POP:   utx_d = UTX_START;
         UTX_START: utx_d = UTX_INUSE;
         UTX_INUSE: if (!tx_busy_i) utx_d = UTX_IDLE;   // frame finished
         default:   utx_d = UTX_IDLE;
      endcase
   end

   always_comb
      if (!bus.addr[14])
         bus.rdata = '0;
      else if (bus.addr[13])
         bus.rdata = {4'b0, tx_wrcount, 4'b0, tx_rdcount, 4'b0, rx_wrcount, 4'b0, rx_rdcount};
      else
         bus.rdata = {52'b0, rx_full, tx_full, rx_empty, rx_dout};   // error bit in rx_dout[8]

   sync_fifo #(.WIDTH(9), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) tx_fifo (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .wr_en_i   (tx_push),
      .din_i     ({1'b0, bus.wdata[7:0]}),
      .rd_en_i   (utx_q == UTX_POP),
      .dout_o    (tx_dout),
      .full_o    (tx_full),
      .empty_o   (tx_empty),
      .wrcount_o (tx_wrcount),
      .rdcount_o (tx_rdcount)
   );

   sync_fifo #(.WIDTH(9), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) rx_fifo (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .wr_en_i   (rx_valid_i),              // lost when full
      .din_i     ({rx_err_i, rx_byte_i}),
      .rd_en_i   (rx_pop),
      .dout_o    (rx_dout),
      .full_o    (rx_full),
      .empty_o   (rx_empty),
      .wrcount_o (rx_wrcount),
      .rdcount_o (rx_rdcount)
   );

endmodule

`default_nettype wire

// File: verilog/board_regs.sv
// board slot: LED output register and registered DIP switch readback
`timescale 1ns/1ps
`default_nettype none

module board_regs
   import periph_pkg::*;
   (
      input  wire          msoc_clk,
      input  wire          rstn,
      host_slot_if.slot    bus,
      output logic [7:0]   to_led_o,
      input  wire  [15:0]  from_dip_i
   );

   logic [15:0]           dip_q;
   logic [HID_DATA_W-1:0] rdata_q;

   assign bus.rdata = rdata_q;   // one cycle behind the address

   always_ff @(posedge msoc_clk or negedge rstn)
      if (!rstn)
      begin
         to_led_o <= '0;
         dip_q    <= '0;
         rdata_q  <= '0;
      end
      else
      begin
         dip_q <= from_dip_i;                    // sampled every cycle
         if (bus.wr && (bus.addr[6:3] == LED_INDEX))
            to_led_o <= bus.wdata[7:0];
         if (bus.sel)
         begin
            if (bus.addr[7:3] == DIP_INDEX)
               rdata_q <= {48'b0, dip_q};
            else
               rdata_q <= {32'b0, BOARD_UNMAPPED};
         end
      end

endmodule

`default_nettype wire

// File: verilog/periph_soc.sv
// peripheral top: decodes the host bus into slots and merges read data from the UART and board slots
`timescale 1ns/1ps
`default_nettype none

module periph_soc
   import periph_pkg::*;
   #(parameter int FIFO_DEPTH_LOG2 = 4)
   (
      input  wire                   msoc_clk,
      input  wire                   rstn,
      input  wire                   hid_en_i,
      input  wire  [HID_BE_W-1:0]   hid_we_i,
      input  wire  [HID_ADDR_W-1:0] hid_addr_i,
      input  wire  [HID_DATA_W-1:0] hid_wrdata_i,
      output logic [HID_DATA_W-1:0] hid_rddata_o,
      input  wire                   uart_rx_i,
      output logic                  uart_tx_o,
      output logic                  uart_irq_o,
      output logic [7:0]            to_led_o,
      input  wire  [15:0]           from_dip_i
   );

   logic [2:0]        slot;
   logic [BAUD_W-1:0] baud;
   logic              tx_start;
   logic              tx_busy;
   logic              rx_valid;
   logic              rx_err;
   logic [7:0]        tx_byte;
   logic [7:0]        rx_byte;

   host_slot_if uart_bus ();
   host_slot_if board_bus ();

   assign slot = hid_addr_i[HID_ADDR_W-1 -: 3];

   assign uart_bus.sel   = hid_en_i & (slot == SLOT_UART);
   assign uart_bus.wr    = uart_bus.sel & (|hid_we_i);
   assign uart_bus.addr  = hid_addr_i[14:0];
   assign uart_bus.wdata = hid_wrdata_i;

   assign board_bus.sel   = hid_en_i & (slot == SLOT_BOARD);
   assign board_bus.wr    = board_bus.sel & (|hid_we_i);
   assign board_bus.addr  = hid_addr_i[14:0];
   assign board_bus.wdata = hid_wrdata_i;

   always_comb
      case (slot)
         SLOT_UART:  hid_rddata_o = uart_bus.rdata;
         SLOT_BOARD: hid_rddata_o = board_bus.rdata;
         default:    hid_rddata_o = '0;            // unused slots
      endcase

   uart_regs #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) uart_regs0 (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .bus        (uart_bus.slot),
      .baud_o     (baud),
      .tx_start_o (tx_start),
      .tx_byte_o  (tx_byte),
      .tx_busy_i  (tx_busy),
      .rx_valid_i (rx_valid),
      .rx_byte_i  (rx_byte),
      .rx_err_i   (rx_err),
      .uart_irq_o (uart_irq_o)
   );

   uart_line uart_line0 (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_i     (baud),
      .tx_start_i (tx_start),
      .tx_byte_i  (tx_byte),
      .tx_busy_o  (tx_busy),
      .uart_tx_o  (uart_tx_o),
      .uart_rx_i  (uart_rx_i),
      .rx_valid_o (rx_valid),
      .rx_byte_o  (rx_byte),
      .rx_err_o   (rx_err)
   );

   board_regs board_regs0 (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .bus        (board_bus.slot),
      .to_led_o   (to_led_o),
      .from_dip_i (from_dip_i)
   );

endmodule

`default_nettype wire

// File: tests/tb_periph_soc.sv
// testbench for periph_soc; reads tests/periph_testdata.txt and runs board, UART and framing checks
`timescale 1ns/1ps
`default_nettype none

module tb_periph_soc;

   localparam logic [17:0] UART_STATUS = 18'h34000;   // slot 6 with bit 14 set
   localparam logic [17:0] UART_COUNTS = 18'h36000;   // bit 13 picks the counters
   localparam logic [17:0] UART_PUSH   = 18'h34000;   // op 0
   localparam logic [17:0] UART_POP    = 18'h35000;   // op 1
   localparam logic [17:0] UART_BAUD   = 18'h36000;   // op 2
   localparam logic [17:0] LED_ADDR    = 18'h10078;   // slot 2 word 15
   localparam logic [17:0] DIP_ADDR    = 18'h100f8;   // word 31
   localparam logic [17:0] OTHER_ADDR  = 18'h10008;
   localparam logic [17:0] SLOT5_ADDR  = 18'h28000;

   logic        msoc_clk;
   logic        rstn;
   logic        hid_en;
   logic [7:0]  hid_we;
   logic [17:0] hid_addr;
   logic [63:0] hid_wrdata;
   logic [63:0] hid_rddata;
   logic        uart_rx;
   logic        uart_tx;
   logic        uart_irq;
   logic [7:0]  to_led;
   logic [15:0] from_dip;
   logic        loopback;
   logic        rx_drive;
   logic [15:0] tdata [0:15];
   logic [15:0] baud;
   logic [63:0] rd;
   int unsigned nbytes;
   int unsigned limit;

   assign uart_rx = loopback ? uart_tx : rx_drive;   // serial loopback switch

   periph_soc #(.FIFO_DEPTH_LOG2(4)) dut0 (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en),
      .hid_we_i     (hid_we),
      .hid_addr_i   (hid_addr),
      .hid_wrdata_i (hid_wrdata),
      .hid_rddata_o (hid_rddata),
      .uart_rx_i    (uart_rx),
      .uart_tx_o    (uart_tx),
      .uart_irq_o   (uart_irq),
      .to_led_o     (to_led),
      .from_dip_i   (from_dip)
   );

   always #20 msoc_clk = ~msoc_clk;

   task automatic expect_equal(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
      if (got !== expected)
      begin
         $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
         $display("Errors found");
         $fatal(1, "value mismatch");
      end
   endtask

   // single-cycle write strobe between two falling edges
   task automatic write_word(input logic [17:0] addr, input logic [63:0] data);
      hid_en     = 1'b1;
      hid_we     = 8'hff;
      hid_addr   = addr;
      hid_wrdata = data;
      @(negedge msoc_clk);
      hid_en = 1'b0;
      hid_we = 8'h00;
   endtask

   task automatic sample_read(input logic [17:0] addr, output logic [63:0] data);
      hid_en   = 1'b1;
      hid_addr = addr;
      #10;
      data = hid_rddata;             // combinational path settles by mid low phase
      @(negedge msoc_clk);
      hid_en = 1'b0;
   endtask

   task automatic delayed_read(input logic [17:0] addr, output logic [63:0] data);
      hid_en   = 1'b1;
      hid_addr = addr;
      @(negedge msoc_clk);           // data registered at the rising edge between
      data   = hid_rddata;
      hid_en = 1'b0;
   endtask

   task automatic await_irq(input int unsigned max_cycles);
      int unsigned n;
      n = 0;
      while (uart_irq !== 1'b1)
      begin
         if (n == max_cycles)
         begin
            $display("Errors found");
            $fatal(1, "timed out waiting for the UART interrupt");
         end
         else
         begin
            n++;
            @(negedge msoc_clk);
         end
      end
   endtask

   // start bit, data lsb first, then the given stop bit
   task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, data, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         rx_drive = frame[4'(i)];
         repeat (baud) @(negedge msoc_clk);
      end
      rx_drive = 1'b1;
   endtask

   initial
   begin
      msoc_clk   = 1'b0;
      rstn       = 1'b0;
      hid_en     = 1'b0;
      hid_we     = 8'h00;
      hid_addr   = 18'h0;
      hid_wrdata = 64'h0;
      from_dip   = 16'h0;
      loopback   = 1'b1;
      rx_drive   = 1'b1;
      $readmemh("tests/periph_testdata.txt", tdata);
      baud  = tdata[0];
      limit = 32'(baud) * 40;        // generous for one frame plus sequencer
      if (tdata[3] inside {[16'd1:16'd8]})
         nbytes = 32'(tdata[3]);
      else
      begin
         $display("Errors found");
         $fatal(1, "test data file gives a bad loopback byte count");
      end
      repeat (10) @(negedge msoc_clk);
      rstn = 1'b1;
      @(negedge msoc_clk);

      // state right after reset
      expect_equal(64'(uart_tx), 64'd1, "uart_tx after reset");
      expect_equal(64'(uart_irq), 64'd0, "uart_irq after reset");
      expect_equal(64'(to_led), 64'd0, "to_led after reset");
      sample_read(UART_STATUS, rd);
      expect_equal(64'(rd[11:9]), 64'b001, "full/empty flags after reset");
      sample_read(UART_COUNTS, rd);
      expect_equal(rd, 64'd0, "counter word after reset");

      // board slot
      write_word(LED_ADDR, 64'(tdata[1][7:0]));
      expect_equal(64'(to_led), 64'(tdata[1][7:0]), "LED register");
      from_dip = tdata[2];
      @(negedge msoc_clk);
      delayed_read(DIP_ADDR, rd);
      expect_equal(rd, 64'(tdata[2]), "DIP readback");
      delayed_read(OTHER_ADDR, rd);
      expect_equal(rd, 64'h0000_0000_dead_beef, "unmapped board word");
      sample_read(SLOT5_ADDR, rd);
      expect_equal(rd, 64'd0, "slot 5 read");

      // loopback through the serializer and the receiver
      write_word(UART_BAUD, 64'(baud));
      for (int i = 0; i < int'(nbytes); i++)
         write_word(UART_PUSH, 64'(tdata[4'(4 + i)][7:0]));
      for (int i = 0; i < int'(nbytes); i++)
      begin
         await_irq(limit);
         sample_read(UART_STATUS, rd);
         expect_equal(64'(rd[8:0]), 64'({1'b0, tdata[4'(4 + i)][7:0]}), "received byte");
         write_word(UART_POP, 64'd0);
      end
      expect_equal(64'(uart_irq), 64'd0, "uart_irq after last pop");

      sample_read(UART_COUNTS, rd);
      expect_equal(64'(rd[59:48]), 64'(nbytes), "tx write count");
      expect_equal(64'(rd[43:32]), 64'(nbytes), "tx read count");
      expect_equal(64'(rd[27:16]), 64'(nbytes), "rx write count");
      expect_equal(64'(rd[11:0]), 64'(nbytes), "rx read count");

      // frame with a low stop bit driven directly
      loopback = 1'b0;
      drive_frame(tdata[12][7:0], 1'b0);
      await_irq(limit);
      sample_read(UART_STATUS, rd);
      expect_equal(64'(rd[8:0]), 64'({1'b1, tdata[12][7:0]}), "framing error byte");
      write_word(UART_POP, 64'd0);
      expect_equal(64'(uart_irq), 64'd0, "uart_irq after error pop");

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/periph_testdata.txt
// word 0 baud divisor, 1 LED value, 2 DIP value, 3 loopback byte count (1..8)
// words 4..11 loopback bytes, word 12 byte sent with a low stop bit
0010
00a5
c3e7
0008
0055
00aa
0000
00ff
0001
0080
003c
00d2
005b

// File: flist.f
verilog/periph_pkg.sv
verilog/host_slot_if.sv
verilog/sync_fifo.sv
verilog/uart_line.sv
verilog/uart_regs.sv
verilog/board_regs.sv
verilog/periph_soc.sv
tests/tb_periph_soc.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_periph_soc
FLIST = flist.f
OBJ   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(SIM)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
